/* source/loop_pkg.sv */
package loop_pkg;

    ////////////////////
    // data widths
    ////////////////////

    // host wire-in, wire-out and pipe word
    localparam int HOST_W = 16;

    // waveform word and spike count
    localparam int WORD_W = 32;

    // half-period setting, host word zero-extended into it
    localparam int HALF_CNT_W = 18;

    // readout address from the host
    localparam int ADDR_W = 8;

    // flops per spike synchronizer chain
    localparam int SYNC_STAGES = 2;

    ////////////////////
    // reset defaults
    ////////////////////

    // half-period after reset_global, tick every 16 cycles
    localparam logic [HALF_CNT_W-1:0] HALF_CNT_RESET = 18'd8;

    ////////////////////
    // wire-out map
    ////////////////////

    localparam logic [ADDR_W-1:0] WO_WAVE_LO = 8'h20;
    localparam logic [ADDR_W-1:0] WO_WAVE_HI = 8'h21;
    localparam logic [ADDR_W-1:0] WO_SL_LO   = 8'h22;
    localparam logic [ADDR_W-1:0] WO_SL_HI   = 8'h23;
    localparam logic [ADDR_W-1:0] WO_LL_LO   = 8'h24;
    localparam logic [ADDR_W-1:0] WO_LL_HI   = 8'h25;
    localparam logic [ADDR_W-1:0] WO_COMB_LO = 8'h26;
    localparam logic [ADDR_W-1:0] WO_COMB_HI = 8'h27;

endpackage

/* source/loop_result_if.sv */
// per-tick results seen by the host readout
// all four are registered levels, no handshake
interface loop_result_if;

    // current replayed waveform word
    logic [loop_pkg::WORD_W-1:0] wave;

    // short-latency spike count, last window
    logic [loop_pkg::WORD_W-1:0] sl_count;

    // long-latency spike count, last window
    logic [loop_pkg::WORD_W-1:0] ll_count;

    // count of the OR of both spikes
    logic [loop_pkg::WORD_W-1:0] comb_count;

    // readout side
    modport sink
    (
        input wave,
        input sl_count,
        input ll_count,
        input comb_count
    );

endinterface

/* source/spike_input_sync.sv */
module spike_input_sync
(
    input  logic ep50trig,
    input  logic reset_global,
    input  logic i_reset_sim,
    input  logic i_spike_mn,
    input  logic i_spike_ll,
    output logic o_pulse_mn,
    output logic o_pulse_ll,
    output logic o_pulse_comb
);

    localparam int NS = loop_pkg::SYNC_STAGES;

    // synchronizer chains, bit 0 samples the pin
    logic [NS-1:0] sync_mn;
    logic [NS-1:0] sync_ll;

    // previous synced levels for edge detect
    logic prev_mn;
    logic prev_ll;
    logic prev_comb;

    // synced levels at the end of each chain
    logic lvl_mn;
    logic lvl_ll;
    logic lvl_comb;

    assign lvl_mn   = sync_mn[NS-1];
    assign lvl_ll   = sync_ll[NS-1];
    // or of synced levels, so one overlap gives one combined edge
    assign lvl_comb = lvl_mn | lvl_ll;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_reset_sim)
        begin
            sync_mn      <= '0;
            sync_ll      <= '0;
            prev_mn      <= 1'b0;
            prev_ll      <= 1'b0;
            prev_comb    <= 1'b0;
            o_pulse_mn   <= 1'b0;
            o_pulse_ll   <= 1'b0;
            o_pulse_comb <= 1'b0;
        end
        else
        begin
            // shift in the async pins
            sync_mn   <= {sync_mn[NS-2:0], i_spike_mn};
            sync_ll   <= {sync_ll[NS-2:0], i_spike_ll};
            prev_mn   <= lvl_mn;
            prev_ll   <= lvl_ll;
            prev_comb <= lvl_comb;
            // one-cycle pulse on a newly high level
            o_pulse_mn   <= lvl_mn & ~prev_mn;
            o_pulse_ll   <= lvl_ll & ~prev_ll;
            o_pulse_comb <= lvl_comb & ~prev_comb;
        end
    end

endmodule

/* source/sim_tick_gen.sv */
module sim_tick_gen
(
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  logic                        i_reset_sim,
    input  logic                        i_trig_load,
    input  logic [loop_pkg::HOST_W-1:0] i_host_word,
    output logic                        o_tick
);

    localparam int HW = loop_pkg::HALF_CNT_W;

    // half-period as loaded by the host
    logic [HW-1:0] half_period;
    // zero treated as one
    logic [HW-1:0] half_eff;
    // last count of a full window, 2*H-1
    logic [HW:0]   win_last;
    // position inside the tick window
    logic [HW:0]   win_cnt;

    assign half_eff = (half_period == '0) ? {{(HW-1){1'b0}}, 1'b1} : half_period;
    assign win_last = {half_eff, 1'b0} - 1'b1;

    ////////////////////
    // half-period reg
    ////////////////////

    // only reset_global restores the default
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
            half_period <= loop_pkg::HALF_CNT_RESET;
        else if (i_trig_load)
            half_period <= {{(HW - loop_pkg::HOST_W){1'b0}}, i_host_word};
    end

    ////////////////////
    // window counter
    ////////////////////

    always_ff @(posedge ep50trig)
    begin
        // a load restarts the window so the new spacing starts clean
        if (reset_global || i_reset_sim || i_trig_load)
        begin
            win_cnt <= '0;
            o_tick  <= 1'b0;
        end
        else if (win_cnt == win_last)
        begin
            // wrap, one tick per 2*H cycles
            win_cnt <= '0;
            o_tick  <= 1'b1;
        end
        else
        begin
            win_cnt <= win_cnt + 1'b1;
            o_tick  <= 1'b0;
        end
    end

endmodule

/* source/wave_buffer.sv */
module wave_buffer
#(
    parameter int WAVE_DEPTH = 64
)
(
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  logic                        i_reset_sim,
    input  logic                        i_pipe_write,
    input  logic [loop_pkg::HOST_W-1:0] i_pipe_data,
    input  logic                        i_tick,
    output logic [loop_pkg::WORD_W-1:0] o_wave
);

    localparam int PTR_W = $clog2(WAVE_DEPTH);
    // count can reach WAVE_DEPTH itself
    localparam int CNT_W = $clog2(WAVE_DEPTH + 1);
    localparam logic [CNT_W-1:0] DEPTH_C = CNT_W'(WAVE_DEPTH);

    // waveform storage
    logic [loop_pkg::WORD_W-1:0] mem [WAVE_DEPTH];

    // low half waiting for its high half
    logic [loop_pkg::HOST_W-1:0] lo_half;
    // 0 expects low half, 1 expects high half
    logic                        hi_phase;
    // words stored so far, also the replay wrap point
    logic [CNT_W-1:0]            wr_count;
    logic [PTR_W-1:0]            rd_ptr;
    logic [CNT_W-1:0]            rd_next;
    logic                        wr_en;
    logic                        rd_en;

    // full word completes on the high half, dropped once full
    assign wr_en   = i_pipe_write & hi_phase & (wr_count < DEPTH_C);
    // replay only once something is loaded
    assign rd_en   = i_tick & (wr_count != '0);
    assign rd_next = CNT_W'(rd_ptr) + CNT_W'(1);

    ////////////////////
    // pipe side
    ////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (i_pipe_write && !hi_phase)
            lo_half <= i_pipe_data;
    end

    always_ff @(posedge ep50trig)
    begin
        if (wr_en)
            mem[wr_count[PTR_W-1:0]] <= {i_pipe_data, lo_half};
    end

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_reset_sim)
        begin
            hi_phase <= 1'b0;
            wr_count <= '0;
        end
        else
        begin
            // phase keeps toggling even when the RAM is full
            if (i_pipe_write)
                hi_phase <= ~hi_phase;
            if (wr_en)
                wr_count <= wr_count + 1'b1;
        end
    end

    ////////////////////
    // replay side
    ////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_reset_sim)
        begin
            rd_ptr <= '0;
            o_wave <= '0;
        end
        else if (rd_en)
        begin
            o_wave <= mem[rd_ptr];
            // cyclic over the stored words
            if (rd_next == wr_count)
                rd_ptr <= '0;
            else
                rd_ptr <= rd_next[PTR_W-1:0];
        end
    end

endmodule

/* source/spike_window_counter.sv */
module spike_window_counter
(
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  logic                        i_reset_sim,
    input  logic                        i_pulse,
    input  logic                        i_tick,
    output logic [loop_pkg::WORD_W-1:0] o_count
);

    // pulses seen in the open window
    logic [loop_pkg::WORD_W-1:0] run_cnt;
    // total of the last closed window
    logic [loop_pkg::WORD_W-1:0] latch_cnt;
    // pulse widened to count width
    logic [loop_pkg::WORD_W-1:0] inc;

    assign inc = {{(loop_pkg::WORD_W - 1){1'b0}}, i_pulse};

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_reset_sim)
        begin
            run_cnt   <= '0;
            latch_cnt <= '0;
        end
        else if (i_tick)
        begin
            // a pulse on the tick cycle still belongs to the closing window
            latch_cnt <= run_cnt + inc;
            run_cnt   <= '0;
        end
        else
        begin
            run_cnt <= run_cnt + inc;
        end
    end

    assign o_count = latch_cnt;

endmodule

/* source/wire_out_mux.sv */
module wire_out_mux
(
    input  logic [loop_pkg::ADDR_W-1:0] i_wo_addr,
    loop_result_if.sink                 results,
    output logic [loop_pkg::HOST_W-1:0] o_wo_data
);

    localparam int HW = loop_pkg::HOST_W;

    // host reads 16 bits at a time, low half at the even address
    always_comb
    begin
        case (i_wo_addr)
            loop_pkg::WO_WAVE_LO:
                o_wo_data = results.wave[HW-1:0];
            loop_pkg::WO_WAVE_HI:
                o_wo_data = results.wave[2*HW-1:HW];
            loop_pkg::WO_SL_LO:
                o_wo_data = results.sl_count[HW-1:0];
            loop_pkg::WO_SL_HI:
                o_wo_data = results.sl_count[2*HW-1:HW];
            loop_pkg::WO_LL_LO:
                o_wo_data = results.ll_count[HW-1:0];
            loop_pkg::WO_LL_HI:
                o_wo_data = results.ll_count[2*HW-1:HW];
            loop_pkg::WO_COMB_LO:
                o_wo_data = results.comb_count[HW-1:0];
            loop_pkg::WO_COMB_HI:
                o_wo_data = results.comb_count[2*HW-1:HW];
            // unmapped addresses read zero
            default:
                o_wo_data = '0;
        endcase
    end

endmodule

/* source/reflex_loop_top.sv */
module reflex_loop_top
#(
    parameter int WAVE_DEPTH = 64
)
(
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  logic                        i_reset_sim,
    input  logic                        i_trig_load,
    input  logic [loop_pkg::HOST_W-1:0] i_host_word,
    input  logic                        i_pipe_write,
    input  logic [loop_pkg::HOST_W-1:0] i_pipe_data,
    input  logic                        i_spike_mn,
    input  logic                        i_spike_ll,
    input  logic [loop_pkg::ADDR_W-1:0] i_wo_addr,
    output logic [loop_pkg::HOST_W-1:0] o_wo_data,
    output logic                        o_tick
);

    // synced spike edges
    logic pulse_mn;
    logic pulse_ll;
    logic pulse_comb;

    // window boundary
    logic tick;

    // results bundle to the readout
    loop_result_if results ();

    ////////////////////
    // input side
    ////////////////////

    spike_input_sync spike_sync
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_reset_sim),
        .i_spike_mn   (i_spike_mn),
        .i_spike_ll   (i_spike_ll),
        .o_pulse_mn   (pulse_mn),
        .o_pulse_ll   (pulse_ll),
        .o_pulse_comb (pulse_comb)
    );

    sim_tick_gen tick_gen
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_reset_sim),
        .i_trig_load  (i_trig_load),
        .i_host_word  (i_host_word),
        .o_tick       (tick)
    );

    // waveform replay, one word per tick
    wave_buffer #(.WAVE_DEPTH(WAVE_DEPTH)) wave_buf
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_reset_sim),
        .i_pipe_write (i_pipe_write),
        .i_pipe_data  (i_pipe_data),
        .i_tick       (tick),
        .o_wave       (results.wave)
    );

    ////////////////////
    // spike counters
    ////////////////////

    // short latency, motor neuron
    spike_window_counter sl_counter
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_reset_sim),
        .i_pulse      (pulse_mn),
        .i_tick       (tick),
        .o_count      (results.sl_count)
    );

    // long latency, cross-board
    spike_window_counter ll_counter
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_reset_sim),
        .i_pulse      (pulse_ll),
        .i_tick       (tick),
        .o_count      (results.ll_count)
    );

    // or of both spike trains
    spike_window_counter comb_counter
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_reset_sim),
        .i_pulse      (pulse_comb),
        .i_tick       (tick),
        .o_count      (results.comb_count)
    );

    wire_out_mux wo_mux
    (
        .i_wo_addr (i_wo_addr),
        .results   (results),
        .o_wo_data (o_wo_data)
    );

    // tick is the only test pin kept
    assign o_tick = tick;

endmodule

/* dv/reflex_loop_asserts.sv */
module reflex_loop_asserts
(
    input logic                        ep50trig,
    input logic                        reset_global,
    input logic                        i_reset_sim,
    input logic [loop_pkg::ADDR_W-1:0] i_wo_addr,
    input logic [loop_pkg::HOST_W-1:0] o_wo_data,
    input logic                        o_tick
);

    timeunit 1ns;
    timeprecision 1ps;

    // read by the testbench
    int fail_count = 0;

    // tick is a single-cycle pulse, even at the shortest spacing
    assert property (@(posedge ep50trig) disable iff (reset_global) o_tick |=> !o_tick)
    else
    begin
        fail_count++;
        $error("tick high on two cycles in a row");
    end

    // either reset clears the tick
    assert property (@(posedge ep50trig) (reset_global || i_reset_sim) |=> !o_tick)
    else
    begin
        fail_count++;
        $error("tick high right after a reset");
    end

    // unmapped readout reads zero
    assert property (@(posedge ep50trig)
        (i_wo_addr < loop_pkg::WO_WAVE_LO || i_wo_addr > loop_pkg::WO_COMB_HI)
        |-> (o_wo_data == '0))
    else
    begin
        fail_count++;
        $error("nonzero readout on an unmapped address");
    end

endmodule

bind reflex_loop_top reflex_loop_asserts asrt (.*);

/* dv/reflex_loop_tb.sv */
module reflex_loop_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HW = loop_pkg::HOST_W;
    localparam int WW = loop_pkg::WORD_W;
    localparam int AW = loop_pkg::ADDR_W;
    // longest spacing used is 64 cycles
    localparam int TICK_TIMEOUT = 200;
    localparam int N_WORDS = 5;
    localparam int N_ENT = 6;
    // just past the wire-out map
    localparam logic [AW-1:0] IDLE_ADDR = 8'h28;

    logic          ep50trig;
    logic          reset_global;
    logic          i_reset_sim;
    logic          i_trig_load;
    logic [HW-1:0] i_host_word;
    logic          i_pipe_write;
    logic [HW-1:0] i_pipe_data;
    logic          i_spike_mn;
    logic          i_spike_ll;
    logic [AW-1:0] i_wo_addr;
    logic [HW-1:0] o_wo_data;
    logic          o_tick;

    int            seed;
    logic [WW-1:0] words [N_WORDS];

    ////////////////////
    // window table
    ////////////////////

    // mn spikes, ll spikes, overlapping pairs
    int ent_mn  [N_ENT] = '{0, 3, 0, 5, 4, 6};
    int ent_ll  [N_ENT] = '{0, 0, 2, 3, 4, 5};
    int ent_ovl [N_ENT] = '{0, 0, 0, 1, 4, 2};
    // expected latched counts per window
    logic [WW-1:0] exp_sl   [N_ENT] = '{32'd0, 32'd3, 32'd0, 32'd5, 32'd4, 32'd6};
    logic [WW-1:0] exp_ll   [N_ENT] = '{32'd0, 32'd0, 32'd2, 32'd3, 32'd4, 32'd5};
    // sl + ll - overlap
    logic [WW-1:0] exp_comb [N_ENT] = '{32'd0, 32'd3, 32'd2, 32'd7, 32'd4, 32'd9};

    reflex_loop_top uut
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_reset_sim),
        .i_trig_load  (i_trig_load),
        .i_host_word  (i_host_word),
        .i_pipe_write (i_pipe_write),
        .i_pipe_data  (i_pipe_data),
        .i_spike_mn   (i_spike_mn),
        .i_spike_ll   (i_spike_ll),
        .i_wo_addr    (i_wo_addr),
        .o_wo_data    (o_wo_data),
        .o_tick       (o_tick)
    );

    // 8 ns period
    always #4 ep50trig = ~ep50trig;

    // stop as soon as the bound checker records a failure
    always @(negedge ep50trig)
    begin
        if (uut.asrt.fail_count != 0)
            fail_stop("a bound assertion on the DUT outputs failed");
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // returns at the falling edge inside the tick cycle
    task automatic wait_tick(input string what);
        int n;
        n = 0;
        @(negedge ep50trig);
        while (o_tick !== 1'b1)
        begin
            n++;
            if (n > TICK_TIMEOUT)
                fail_stop($sformatf("Timeout: no tick seen while waiting for %s", what));
            @(negedge ep50trig);
        end
    endtask

    // one half per cycle
    // sampled mid low phase
    task automatic read_word(input logic [AW-1:0] lo_addr, input logic [AW-1:0] hi_addr,
                             output logic [WW-1:0] value);
        @(negedge ep50trig);
        i_wo_addr = lo_addr;
        #2;
        value[HW-1:0] = o_wo_data;
        @(negedge ep50trig);
        i_wo_addr = hi_addr;
        #2;
        value[WW-1:HW] = o_wo_data;
        // park on an unmapped address while results are live
        i_wo_addr = IDLE_ADDR;
    endtask

    task automatic check_count(input logic [AW-1:0] lo_addr, input logic [AW-1:0] hi_addr,
                               input logic [WW-1:0] expected, input string name);
        logic [WW-1:0] actual;
        read_word(lo_addr, hi_addr, actual);
        if (actual !== expected)
            fail_stop($sformatf("Mismatch at %0t: %s count expected %0d got %0d",
                                $time, name, expected, actual));
    endtask

    task automatic check_wave(input logic [WW-1:0] expected, input int idx);
        logic [WW-1:0] actual;
        read_word(loop_pkg::WO_WAVE_LO, loop_pkg::WO_WAVE_HI, actual);
        if (actual !== expected)
            fail_stop($sformatf("Mismatch at %0t: wave read %0d expected %h got %h",
                                $time, idx, expected, actual));
    endtask

    // counts cycles from one tick to the next
    task automatic check_tick_gap(input int exp_gap);
        int gap;
        wait_tick("first tick of gap");
        gap = 0;
        do
        begin
            @(negedge ep50trig);
            gap++;
            if (gap > TICK_TIMEOUT)
                fail_stop("Timeout: second tick of gap never came");
        end
        while (o_tick !== 1'b1);
        if (gap != exp_gap)
            fail_stop($sformatf("Mismatch at %0t: tick gap expected %0d got %0d",
                                $time, exp_gap, gap));
    endtask

    task automatic load_half(input logic [HW-1:0] word);
        @(negedge ep50trig);
        i_trig_load = 1'b1;
        i_host_word = word;
        @(negedge ep50trig);
        i_trig_load = 1'b0;
    endtask

    // low half first
    task automatic write_word(input logic [WW-1:0] w);
        @(negedge ep50trig);
        i_pipe_write = 1'b1;
        i_pipe_data  = w[HW-1:0];
        @(negedge ep50trig);
        i_pipe_data  = w[WW-1:HW];
        @(negedge ep50trig);
        i_pipe_write = 1'b0;
    endtask

    // 2 cycles high and 2 low per slot
    // overlapping pairs take the first slots
    task automatic drive_window(input int n_mn, input int n_ll, input int n_ovl);
        int slots;
        slots = n_mn + n_ll - n_ovl;
        for (int s = 0; s < slots; s++)
        begin
            i_spike_mn = (s < n_mn);
            i_spike_ll = (s < n_ovl) || (s >= n_mn);
            repeat (2) @(negedge ep50trig);
            i_spike_mn = 1'b0;
            i_spike_ll = 1'b0;
            repeat (2) @(negedge ep50trig);
        end
    endtask

    task automatic check_all_counts(input logic [WW-1:0] sl, input logic [WW-1:0] ll,
                                    input logic [WW-1:0] comb);
        check_count(loop_pkg::WO_SL_LO, loop_pkg::WO_SL_HI, sl, "short-latency");
        check_count(loop_pkg::WO_LL_LO, loop_pkg::WO_LL_HI, ll, "long-latency");
        check_count(loop_pkg::WO_COMB_LO, loop_pkg::WO_COMB_HI, comb, "combined");
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial
    begin
        seed         = 45;
        ep50trig     = 1'b0;
        reset_global = 1'b1;
        i_reset_sim  = 1'b1;
        i_trig_load  = 1'b0;
        i_host_word  = '0;
        i_pipe_write = 1'b0;
        i_pipe_data  = '0;
        i_spike_mn   = 1'b0;
        i_spike_ll   = 1'b0;
        i_wo_addr    = '0;
        repeat (16) @(negedge ep50trig);
        reset_global = 1'b0;
        i_reset_sim  = 1'b0;

        // readouts clear after reset
        check_all_counts('0, '0, '0);
        check_wave('0, 0);
        // default tick spacing
        check_tick_gap(2 * loop_pkg::HALF_CNT_RESET);

        // host reload of the half-period
        load_half(16'd20);
        check_tick_gap(40);
        // zero acts as one
        load_half(16'd0);
        check_tick_gap(2);
        // wide windows for the rest
        load_half(16'd32);

        // fill right after a tick so no replay starts mid-load
        wait_tick("pipe load");
        for (int i = 0; i < N_WORDS; i++)
        begin
            words[i] = $random(seed);
            write_word(words[i]);
        end
        for (int t = 0; t < 12; t++)
        begin
            wait_tick("waveform replay");
            check_wave(words[t % N_WORDS], t);
        end

        // one spike window per entry with an idle window between
        for (int e = 0; e < N_ENT; e++)
        begin
            wait_tick("window open");
            repeat (2) @(negedge ep50trig);
            drive_window(ent_mn[e], ent_ll[e], ent_ovl[e]);
            wait_tick("window close");
            check_all_counts(exp_sl[e], exp_ll[e], exp_comb[e]);
        end

        // sim reset clears counts and empties the buffer
        @(negedge ep50trig);
        i_reset_sim = 1'b1;
        repeat (2) @(negedge ep50trig);
        i_reset_sim = 1'b0;
        check_all_counts('0, '0, '0);
        check_wave('0, 0);
        for (int w = 0; w < 2; w++)
        begin
            wait_tick("quiet window");
            check_all_counts('0, '0, '0);
            check_wave('0, w);
        end

        if (uut.asrt.fail_count != 0)
        begin
            fail_stop("bound assertions failed during the run");
        end
        else
        begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

/* project.f */
source/loop_pkg.sv
source/loop_result_if.sv
source/spike_input_sync.sv
source/sim_tick_gen.sv
source/wave_buffer.sv
source/spike_window_counter.sv
source/wire_out_mux.sv
source/reflex_loop_top.sv
dv/reflex_loop_asserts.sv
dv/reflex_loop_tb.sv

/* Bender.yml */
package:
  name: reflex_loop

sources:
  - source/loop_pkg.sv
  - source/loop_result_if.sv
  - source/spike_input_sync.sv
  - source/sim_tick_gen.sv
  - source/wave_buffer.sv
  - source/spike_window_counter.sv
  - source/wire_out_mux.sv
  - source/reflex_loop_top.sv
  - target: test
    files:
      - dv/reflex_loop_asserts.sv
      - dv/reflex_loop_tb.sv
